/* rtl/issue_consts.svh */
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

`define ID_XLEN       32
`define ID_NREG_W     5
`define ID_ALU_OP_W   12

// one-hot alu op positions
`define ID_ALU_ADD    0
`define ID_ALU_SUB    1
`define ID_ALU_SLT    2
`define ID_ALU_SLTU   3
`define ID_ALU_AND    4
`define ID_ALU_NOR    5
`define ID_ALU_OR     6
`define ID_ALU_XOR    7
`define ID_ALU_SLL    8
`define ID_ALU_SRL    9
`define ID_ALU_SRA    10
`define ID_ALU_LUI    11

// 3R and shift-imm forms, matched on inst[31:15]
`define ID_OP_ADD_W   17'h00020
`define ID_OP_SUB_W   17'h00022
`define ID_OP_SLT     17'h00024
`define ID_OP_SLTU    17'h00025
`define ID_OP_NOR     17'h00028
`define ID_OP_AND     17'h00029
`define ID_OP_OR      17'h0002a
`define ID_OP_XOR     17'h0002b
`define ID_OP_SLL_W   17'h0002e
`define ID_OP_SRL_W   17'h0002f
`define ID_OP_SRA_W   17'h00030
`define ID_OP_SLLI_W  17'h00081
`define ID_OP_SRLI_W  17'h00089
`define ID_OP_SRAI_W  17'h00091

// 2RI12 forms, matched on inst[31:22]
`define ID_OP_ADDI_W  10'h00a
`define ID_OP_SLTI    10'h008
`define ID_OP_SLTUI   10'h009
`define ID_OP_ANDI    10'h00d
`define ID_OP_ORI     10'h00e
`define ID_OP_XORI    10'h00f
`define ID_OP_LD_W    10'h0a2
`define ID_OP_ST_W    10'h0a6

// 1RI20 forms on inst[31:25]
`define ID_OP_LU12I_W   7'h0a
`define ID_OP_PCADDU12I 7'h0e

// branches on inst[31:26]
`define ID_OP_JIRL    6'h13
`define ID_OP_B       6'h14
`define ID_OP_BL      6'h15
`define ID_OP_BEQ     6'h16
`define ID_OP_BNE     6'h17
`define ID_OP_BLT     6'h18
`define ID_OP_BGE     6'h19
`define ID_OP_BLTU    6'h1a
`define ID_OP_BGEU    6'h1b

`define ID_LINK_REG   5'd1

`endif

/* rtl/issue_pkg.sv */
`include "issue_consts.svh"

package issue_pkg;

    typedef logic [`ID_XLEN-1:0]     word_t;
    typedef logic [`ID_NREG_W-1:0]   reg_idx_t;
    typedef logic [`ID_ALU_OP_W-1:0] alu_op_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_bus_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_bus_t;

    typedef struct packed {
        logic     valid;
        logic     is_load; // data not ready yet
        reg_idx_t dest;
        word_t    wdata;
    } ex_fwd_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    wdata;
    } mem_fwd_t;

    typedef struct packed {
        logic     we;
        reg_idx_t waddr;
        word_t    wdata;
    } wb_bus_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     need_rj;
        logic     need_rkd;
        logic     gr_we;
        logic     mem_we;
        logic     res_from_mem;
        logic     beq, bne, blt, bge, bltu, bgeu;
        logic     b, bl, jirl;
        reg_idx_t rj;
        reg_idx_t rkd_idx; // rd for stores and compares
        reg_idx_t dest;
        word_t    imm;
        word_t    br_offs;
    } dec_t;

    typedef struct packed {
        logic     gr_we;
        logic     mem_we;
        logic     res_from_mem;
        alu_op_t  alu_op;
        word_t    alu_src1;
        word_t    alu_src2;
        reg_idx_t dest;
        word_t    store_data;
        word_t    pc;
    } issue_bus_t;

endpackage

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`include "issue_consts.svh"

module inst_decoder import issue_pkg::*; (
    input  word_t inst,
    output dec_t  dec
);
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    reg_idx_t    rd, rj, rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and, inst_or;
    logic inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_ld_w, inst_st_w, inst_lu12i_w, inst_pcaddu12i;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic inst_b, inst_bl, inst_jirl;
    logic inst_cmp_br, alu_3r, alu_imm;
    logic need_ui5, need_si12, need_ui12, need_si20, src2_is_4;
    word_t imm;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];
    assign i12  = inst[21:10];
    assign i16  = inst[25:10];
    assign i20  = inst[24:5];
    assign i26  = {inst[9:0], inst[25:10]}; // offs[25:16] sits in the low bits

    assign inst_add_w     = op17 == `ID_OP_ADD_W;
    assign inst_sub_w     = op17 == `ID_OP_SUB_W;
    assign inst_slt       = op17 == `ID_OP_SLT;
    assign inst_sltu      = op17 == `ID_OP_SLTU;
    assign inst_nor       = op17 == `ID_OP_NOR;
    assign inst_and       = op17 == `ID_OP_AND;
    assign inst_or        = op17 == `ID_OP_OR;
    assign inst_xor       = op17 == `ID_OP_XOR;
    assign inst_sll_w     = op17 == `ID_OP_SLL_W;
    assign inst_srl_w     = op17 == `ID_OP_SRL_W;
    assign inst_sra_w     = op17 == `ID_OP_SRA_W;
    assign inst_slli_w    = op17 == `ID_OP_SLLI_W;
    assign inst_srli_w    = op17 == `ID_OP_SRLI_W;
    assign inst_srai_w    = op17 == `ID_OP_SRAI_W;
    assign inst_addi_w    = op10 == `ID_OP_ADDI_W;
    assign inst_slti      = op10 == `ID_OP_SLTI;
    assign inst_sltui     = op10 == `ID_OP_SLTUI;
    assign inst_andi      = op10 == `ID_OP_ANDI;
    assign inst_ori       = op10 == `ID_OP_ORI;
    assign inst_xori      = op10 == `ID_OP_XORI;
    assign inst_ld_w      = op10 == `ID_OP_LD_W;
    assign inst_st_w      = op10 == `ID_OP_ST_W;
    assign inst_lu12i_w   = op7 == `ID_OP_LU12I_W;
    assign inst_pcaddu12i = op7 == `ID_OP_PCADDU12I;
    assign inst_beq       = op6 == `ID_OP_BEQ;
    assign inst_bne       = op6 == `ID_OP_BNE;
    assign inst_blt       = op6 == `ID_OP_BLT;
    assign inst_bge       = op6 == `ID_OP_BGE;
    assign inst_bltu      = op6 == `ID_OP_BLTU;
    assign inst_bgeu      = op6 == `ID_OP_BGEU;
    assign inst_b         = op6 == `ID_OP_B;
    assign inst_bl        = op6 == `ID_OP_BL;
    assign inst_jirl      = op6 == `ID_OP_JIRL;

    assign alu_3r  = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                   | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    assign alu_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_slti
                   | inst_sltui | inst_andi | inst_ori | inst_xori;
    assign inst_cmp_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign src2_is_4 = inst_jirl | inst_bl; // link value is pc + 4

    assign imm = src2_is_4 ? 32'd4                   :
                 need_si20 ? {i20, 12'b0}            :
                 need_ui5  ? {27'b0, rk}             :
                 need_si12 ? {{20{i12[11]}}, i12}    :
                 need_ui12 ? {20'b0, i12}            : '0;

    always_comb begin
        dec = '0;
        dec.beq  = inst_beq;
        dec.bne  = inst_bne;
        dec.blt  = inst_blt;
        dec.bge  = inst_bge;
        dec.bltu = inst_bltu;
        dec.bgeu = inst_bgeu;
        dec.b    = inst_b;
        dec.bl   = inst_bl;
        dec.jirl = inst_jirl;

        dec.alu_op[`ID_ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                 | inst_jirl | inst_bl | inst_pcaddu12i;
        dec.alu_op[`ID_ALU_SUB]  = inst_sub_w;
        dec.alu_op[`ID_ALU_SLT]  = inst_slt | inst_slti;
        dec.alu_op[`ID_ALU_SLTU] = inst_sltu | inst_sltui;
        dec.alu_op[`ID_ALU_AND]  = inst_and | inst_andi;
        dec.alu_op[`ID_ALU_NOR]  = inst_nor;
        dec.alu_op[`ID_ALU_OR]   = inst_or | inst_ori;
        dec.alu_op[`ID_ALU_XOR]  = inst_xor | inst_xori;
        dec.alu_op[`ID_ALU_SLL]  = inst_sll_w | inst_slli_w;
        dec.alu_op[`ID_ALU_SRL]  = inst_srl_w | inst_srli_w;
        dec.alu_op[`ID_ALU_SRA]  = inst_sra_w | inst_srai_w;
        dec.alu_op[`ID_ALU_LUI]  = inst_lu12i_w;

        dec.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
        dec.src2_is_imm  = need_ui5 | need_si12 | need_ui12 | need_si20 | src2_is_4;
        dec.need_rj      = alu_3r | alu_imm | inst_ld_w | inst_st_w | inst_cmp_br | inst_jirl;
        dec.need_rkd     = alu_3r | inst_st_w | inst_cmp_br;
        // unknown words fall through with no write
        dec.gr_we        = alu_3r | alu_imm | inst_ld_w | need_si20 | inst_jirl | inst_bl;
        dec.mem_we       = inst_st_w;
        dec.res_from_mem = inst_ld_w;

        dec.rj      = rj;
        dec.rkd_idx = (inst_st_w | inst_cmp_br) ? rd : rk;
        dec.dest    = rd;
        dec.imm     = imm;
        dec.br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                         : {{14{i16[15]}}, i16, 2'b0};
    end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ps
`include "issue_consts.svh"

module regfile import issue_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  wb_bus_t  wb
);
    localparam int NREG = 1 << `ID_NREG_W;

    word_t rf [NREG];

    always_ff @(posedge clk) begin
        if (wb.we && wb.waddr != '0) begin
            rf[wb.waddr] <= wb.wdata;
        end
    end

    // r0 is hardwired, its storage is never written
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

/* rtl/operand_fwd.sv */
`timescale 1ns/1ps

module operand_fwd import issue_pkg::*; (
    input  logic     clk,
    input  dec_t     dec,
    input  ex_fwd_t  ex_fwd,
    input  mem_fwd_t mem_fwd,
    input  wb_bus_t  wb,
    output word_t    rj_value,
    output word_t    rkd_value,
    output logic     load_use
);
    word_t rf_rdata1, rf_rdata2;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.rj),
        .raddr2 (dec.rkd_idx),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wb     (wb)
    );

    // youngest producer wins
    function automatic word_t pick(reg_idx_t idx, logic need, word_t rf_val,
                                   ex_fwd_t ex, mem_fwd_t mem, wb_bus_t wr);
        if (need && idx != '0 && ex.valid && ex.dest == idx)
            return ex.wdata;
        if (need && idx != '0 && mem.valid && mem.dest == idx)
            return mem.wdata;
        if (need && idx != '0 && wr.we && wr.waddr == idx)
            return wr.wdata; // same-cycle write
        return rf_val;
    endfunction

    always_comb begin
        rj_value  = pick(dec.rj, dec.need_rj, rf_rdata1, ex_fwd, mem_fwd, wb);
        rkd_value = pick(dec.rkd_idx, dec.need_rkd, rf_rdata2, ex_fwd, mem_fwd, wb);
    end

    assign load_use = ex_fwd.valid && ex_fwd.is_load &&
                      ((dec.need_rj && dec.rj != '0 && ex_fwd.dest == dec.rj) ||
                       (dec.need_rkd && dec.rkd_idx != '0 && ex_fwd.dest == dec.rkd_idx));

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import issue_pkg::*; (
    input  dec_t  dec,
    input  word_t pc,
    input  word_t rj_value,
    input  word_t rkd_value,
    output logic  br_cond,
    output word_t br_target
);
    logic eq, lt_s, lt_u;

    assign eq   = rj_value == rkd_value;
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    assign br_cond = (dec.beq  &  eq)
                   | (dec.bne  & ~eq)
                   | (dec.blt  &  lt_s)
                   | (dec.bge  & ~lt_s)
                   | (dec.bltu &  lt_u)
                   | (dec.bgeu & ~lt_u)
                   | dec.b | dec.bl | dec.jirl; // unconditional

    // br_offs already holds si16 << 2 for jirl
    assign br_target = (dec.jirl ? rj_value : pc) + dec.br_offs;

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`include "issue_consts.svh"

module id_stage import issue_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       if_valid,
    output logic       id_allowin,
    input  fetch_bus_t if_bus,
    output br_bus_t    br_bus,
    input  logic       ex_allowin,
    output logic       id_ex_valid,
    output issue_bus_t id_ex_bus,
    input  ex_fwd_t    ex_fwd,
    input  mem_fwd_t   mem_fwd,
    input  wb_bus_t    wb_bus
);
    logic       id_valid;
    fetch_bus_t ir;
    dec_t       dec;
    word_t      rj_value, rkd_value, br_target;
    logic       load_use, br_cond, id_leave;

    assign id_ex_valid = id_valid & ~load_use;
    assign id_leave    = id_ex_valid & ex_allowin;
    assign id_allowin  = ~id_valid | id_leave;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_bus.taken) begin
            id_valid <= 1'b0; // drop the wrong-path fetch
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            ir <= if_bus;
        end
    end

    inst_decoder u_dec (.inst(ir.inst), .dec(dec));

    operand_fwd u_fwd (
        .clk       (clk),
        .dec       (dec),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb        (wb_bus),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .load_use  (load_use)
    );

    branch_unit u_br (
        .dec       (dec),
        .pc        (ir.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_cond   (br_cond),
        .br_target (br_target)
    );

    assign br_bus = '{taken: br_cond & id_leave, target: br_target};

    assign id_ex_bus = '{
        gr_we:        dec.gr_we,
        mem_we:       dec.mem_we,
        res_from_mem: dec.res_from_mem,
        alu_op:       dec.alu_op,
        alu_src1:     dec.src1_is_pc ? ir.pc : rj_value,
        alu_src2:     dec.src2_is_imm ? dec.imm : rkd_value,
        dest:         dec.bl ? `ID_LINK_REG : dec.dest,
        store_data:   rkd_value,
        pc:           ir.pc
    };

endmodule

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

/* dv/id_checker.sv */
`timescale 1ns/1ps
`include "issue_consts.svh"

module id_checker import issue_pkg::*; (
    input logic       clk,
    input logic       resetn,
    input logic       if_valid,
    input logic       id_allowin,
    input fetch_bus_t if_bus,
    input br_bus_t    br_bus,
    input logic       ex_allowin,
    input logic       id_ex_valid,
    input issue_bus_t id_ex_bus,
    input ex_fwd_t    ex_fwd,
    input mem_fwd_t   mem_fwd,
    input wb_bus_t    wb_bus
);
    int err_count   = 0;
    int check_count = 0;
    int leave_count = 0;
    int taken_count = 0;

    word_t      shadow [32];
    logic       m_valid;
    word_t      m_pc, m_inst;
    issue_bus_t e;
    logic       c1, c2, tk, lu, exp_valid, leave, exp_taken, allow;
    word_t      tg;

    function automatic alu_op_t onehot(int p);
        alu_op_t v;
        v = '0;
        v[p[3:0]] = 1'b1;
        return v;
    endfunction

    // newest producer first, r0 is always zero
    function automatic word_t opnd(reg_idx_t idx, logic need);
        if (idx == '0)
            return '0;
        if (need && ex_fwd.valid && ex_fwd.dest == idx)
            return ex_fwd.wdata;
        if (need && mem_fwd.valid && mem_fwd.dest == idx)
            return mem_fwd.wdata;
        if (need && wb_bus.we && wb_bus.waddr == idx)
            return wb_bus.wdata;
        return shadow[idx];
    endfunction

    task automatic compare(string name, word_t got, word_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic void ref_model(input word_t inst, input word_t pc,
                                      output issue_bus_t r, output logic s1_chk,
                                      output logic s2_chk, output logic taken,
                                      output word_t target, output logic stall);
        reg_idx_t rd, rj, rk, i2;
        logic     n1, n2, s1pc, s2imm, g12;
        word_t    imm, v1, v2, o16, o26, se12, ze12;
        int       bk;
        r = '0;
        n1 = 1'b0;
        n2 = 1'b0;
        s1pc = 1'b0;
        s2imm = 1'b0;
        g12 = 1'b0;
        imm = '0;
        bk = 0;
        taken = 1'b0;
        rd = inst[4:0];
        rj = inst[9:5];
        rk = inst[14:10];
        i2 = rk;
        o16 = {{14{inst[25]}}, inst[25:10], 2'b0};
        o26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
        se12 = {{20{inst[21]}}, inst[21:10]};
        ze12 = {20'b0, inst[21:10]};
        r.dest = rd;
        case (inst[31:15])
            `ID_OP_ADD_W:  r.alu_op = onehot(`ID_ALU_ADD);
            `ID_OP_SUB_W:  r.alu_op = onehot(`ID_ALU_SUB);
            `ID_OP_SLT:    r.alu_op = onehot(`ID_ALU_SLT);
            `ID_OP_SLTU:   r.alu_op = onehot(`ID_ALU_SLTU);
            `ID_OP_NOR:    r.alu_op = onehot(`ID_ALU_NOR);
            `ID_OP_AND:    r.alu_op = onehot(`ID_ALU_AND);
            `ID_OP_OR:     r.alu_op = onehot(`ID_ALU_OR);
            `ID_OP_XOR:    r.alu_op = onehot(`ID_ALU_XOR);
            `ID_OP_SLL_W:  r.alu_op = onehot(`ID_ALU_SLL);
            `ID_OP_SRL_W:  r.alu_op = onehot(`ID_ALU_SRL);
            `ID_OP_SRA_W:  r.alu_op = onehot(`ID_ALU_SRA);
            `ID_OP_SLLI_W: begin r.alu_op = onehot(`ID_ALU_SLL); s2imm = 1'b1; end
            `ID_OP_SRLI_W: begin r.alu_op = onehot(`ID_ALU_SRL); s2imm = 1'b1; end
            `ID_OP_SRAI_W: begin r.alu_op = onehot(`ID_ALU_SRA); s2imm = 1'b1; end
            default: ;
        endcase
        if (r.alu_op != '0) begin
            n1 = 1'b1;
            n2 = !s2imm;
            r.gr_we = 1'b1;
            imm = {27'b0, rk}; // ui5 for the shift forms
        end
        case (inst[31:22])
            `ID_OP_ADDI_W: begin r.alu_op = onehot(`ID_ALU_ADD);  imm = se12; g12 = 1'b1; end
            `ID_OP_SLTI:   begin r.alu_op = onehot(`ID_ALU_SLT);  imm = se12; g12 = 1'b1; end
            `ID_OP_SLTUI:  begin r.alu_op = onehot(`ID_ALU_SLTU); imm = se12; g12 = 1'b1; end
            `ID_OP_ANDI:   begin r.alu_op = onehot(`ID_ALU_AND);  imm = ze12; g12 = 1'b1; end
            `ID_OP_ORI:    begin r.alu_op = onehot(`ID_ALU_OR);   imm = ze12; g12 = 1'b1; end
            `ID_OP_XORI:   begin r.alu_op = onehot(`ID_ALU_XOR);  imm = ze12; g12 = 1'b1; end
            `ID_OP_LD_W: begin
                r.alu_op = onehot(`ID_ALU_ADD);
                imm = se12;
                g12 = 1'b1;
                r.res_from_mem = 1'b1;
            end
            `ID_OP_ST_W: begin
                r.alu_op = onehot(`ID_ALU_ADD);
                imm = se12;
                g12 = 1'b1;
                r.mem_we = 1'b1;
                n2 = 1'b1;
                i2 = rd; // store data comes from rd
            end
            default: ;
        endcase
        if (g12) begin
            n1 = 1'b1;
            s2imm = 1'b1;
            r.gr_we = !r.mem_we;
        end
        case (inst[31:25])
            `ID_OP_LU12I_W: begin
                r.alu_op = onehot(`ID_ALU_LUI);
                s2imm = 1'b1;
                imm = {inst[24:5], 12'b0};
                r.gr_we = 1'b1;
            end
            `ID_OP_PCADDU12I: begin
                r.alu_op = onehot(`ID_ALU_ADD);
                s1pc = 1'b1;
                s2imm = 1'b1;
                imm = {inst[24:5], 12'b0};
                r.gr_we = 1'b1;
            end
            default: ;
        endcase
        case (inst[31:26])
            `ID_OP_BEQ:  bk = 1;
            `ID_OP_BNE:  bk = 2;
            `ID_OP_BLT:  bk = 3;
            `ID_OP_BGE:  bk = 4;
            `ID_OP_BLTU: bk = 5;
            `ID_OP_BGEU: bk = 6;
            `ID_OP_B:    taken = 1'b1;
            `ID_OP_BL, `ID_OP_JIRL: begin
                taken = 1'b1;
                n1 = inst[31:26] == `ID_OP_JIRL;
                r.alu_op = onehot(`ID_ALU_ADD);
                s1pc = 1'b1;
                s2imm = 1'b1;
                imm = 32'd4; // link is pc + 4
                r.gr_we = 1'b1;
                if (inst[31:26] == `ID_OP_BL)
                    r.dest = `ID_LINK_REG;
            end
            default: ;
        endcase
        if (bk != 0) begin
            n1 = 1'b1;
            n2 = 1'b1;
            i2 = rd;
        end
        v1 = opnd(rj, n1);
        v2 = opnd(i2, n2);
        case (bk)
            1: taken = v1 == v2;
            2: taken = v1 != v2;
            3: taken = $signed(v1) < $signed(v2);
            4: taken = $signed(v1) >= $signed(v2);
            5: taken = v1 < v2;
            6: taken = v1 >= v2;
            default: ;
        endcase
        if (inst[31:26] == `ID_OP_JIRL)
            target = v1 + o16;
        else if (inst[31:26] == `ID_OP_B || inst[31:26] == `ID_OP_BL)
            target = pc + o26;
        else
            target = pc + o16;
        r.alu_src1 = s1pc ? pc : v1;
        r.alu_src2 = s2imm ? imm : v2;
        r.store_data = v2;
        r.pc = pc;
        s1_chk = s1pc | n1;
        s2_chk = s2imm | n2;
        stall = ex_fwd.valid && ex_fwd.is_load &&
                ((n1 && rj != '0 && ex_fwd.dest == rj) || (n2 && i2 != '0 && ex_fwd.dest == i2));
    endfunction

    always @(posedge clk) begin
        if (wb_bus.we && wb_bus.waddr != '0)
            shadow[wb_bus.waddr] <= wb_bus.wdata;
        if (!resetn) begin
            m_valid <= 1'b0;
        end else begin
            ref_model(m_inst, m_pc, e, c1, c2, tk, tg, lu);
            exp_valid = m_valid & ~lu;
            leave     = exp_valid & ex_allowin;
            exp_taken = leave & tk;
            allow     = ~m_valid | leave;
            compare("id_ex_valid", {31'b0, id_ex_valid}, {31'b0, exp_valid});
            compare("id_allowin", {31'b0, id_allowin}, {31'b0, allow});
            compare("br_bus.taken", {31'b0, br_bus.taken}, {31'b0, exp_taken});
            if (leave) begin
                leave_count++;
                compare("gr_we", {31'b0, id_ex_bus.gr_we}, {31'b0, e.gr_we});
                compare("mem_we", {31'b0, id_ex_bus.mem_we}, {31'b0, e.mem_we});
                compare("res_from_mem", {31'b0, id_ex_bus.res_from_mem},
                        {31'b0, e.res_from_mem});
                compare("alu_op", {20'b0, id_ex_bus.alu_op}, {20'b0, e.alu_op});
                compare("dest", {27'b0, id_ex_bus.dest}, {27'b0, e.dest});
                compare("pc", id_ex_bus.pc, e.pc);
                if (c1)
                    compare("alu_src1", id_ex_bus.alu_src1, e.alu_src1);
                if (c2)
                    compare("alu_src2", id_ex_bus.alu_src2, e.alu_src2);
                if (e.mem_we)
                    compare("store_data", id_ex_bus.store_data, e.store_data);
            end
            if (exp_taken) begin
                taken_count++;
                compare("br_bus.target", br_bus.target, tg);
            end
            // wrong-path fetch is dropped on a taken branch
            if (exp_taken)
                m_valid <= 1'b0;
            else if (allow)
                m_valid <= if_valid;
            if (if_valid && allow) begin
                m_pc   <= if_bus.pc;
                m_inst <= if_bus.inst;
            end
        end
    end

endmodule

/* dv/id_stage_tb.sv */
`timescale 1ns/1ps
`include "issue_consts.svh"

module id_stage_tb import issue_pkg::*; #(
    parameter int SEED = 42578
);
    localparam logic [16:0] OPS17 [14] = '{`ID_OP_ADD_W, `ID_OP_SUB_W, `ID_OP_SLT, `ID_OP_SLTU,
        `ID_OP_NOR, `ID_OP_AND, `ID_OP_OR, `ID_OP_XOR, `ID_OP_SLL_W, `ID_OP_SRL_W,
        `ID_OP_SRA_W, `ID_OP_SLLI_W, `ID_OP_SRLI_W, `ID_OP_SRAI_W};
    localparam logic [9:0] OPS10 [8] = '{`ID_OP_ADDI_W, `ID_OP_SLTI, `ID_OP_SLTUI,
        `ID_OP_ANDI, `ID_OP_ORI, `ID_OP_XORI, `ID_OP_LD_W, `ID_OP_ST_W};
    localparam logic [6:0] OPS7 [2] = '{`ID_OP_LU12I_W, `ID_OP_PCADDU12I};
    localparam logic [5:0] OPS6 [9] = '{`ID_OP_BEQ, `ID_OP_BNE, `ID_OP_BLT, `ID_OP_BGE,
        `ID_OP_BLTU, `ID_OP_BGEU, `ID_OP_B, `ID_OP_BL, `ID_OP_JIRL};

    logic       clk, resetn, if_valid, id_allowin, ex_allowin, id_ex_valid, ok;
    fetch_bus_t if_bus;
    br_bus_t    br_bus;
    issue_bus_t id_ex_bus;
    ex_fwd_t    ex_fwd;
    mem_fwd_t   mem_fwd;
    wb_bus_t    wb_bus;
    integer     seed;

    tb_clkgen #(.PERIOD(100)) i_clk (.clk(clk));

    id_stage i_dut (
        .clk(clk), .resetn(resetn), .if_valid(if_valid), .id_allowin(id_allowin),
        .if_bus(if_bus), .br_bus(br_bus), .ex_allowin(ex_allowin), .id_ex_valid(id_ex_valid),
        .id_ex_bus(id_ex_bus), .ex_fwd(ex_fwd), .mem_fwd(mem_fwd), .wb_bus(wb_bus)
    );

    id_checker i_chk (
        .clk(clk), .resetn(resetn), .if_valid(if_valid), .id_allowin(id_allowin),
        .if_bus(if_bus), .br_bus(br_bus), .ex_allowin(ex_allowin), .id_ex_valid(id_ex_valid),
        .id_ex_bus(id_ex_bus), .ex_fwd(ex_fwd), .mem_fwd(mem_fwd), .wb_bus(wb_bus)
    );

    // registers limited to r0..r7 so hazards collide often
    function automatic word_t make_inst(int k, word_t w);
        int t;
        t = k;
        if (t < 14)
            return {OPS17[t[3:0]], 2'b0, w[12:10], 2'b0, w[7:5], 2'b0, w[2:0]};
        t = t - 14;
        if (t < 8)
            return {OPS10[t[2:0]], w[21:10], 2'b0, w[7:5], 2'b0, w[2:0]};
        t = t - 8;
        if (t < 2)
            return {OPS7[t[0]], w[24:5], 2'b0, w[2:0]};
        t = t - 2;
        if (t == 6 || t == 7)
            return {OPS6[t[3:0]], w[25:0]}; // b and bl use all 26 offset bits
        return {OPS6[t[3:0]], w[25:10], 2'b0, w[7:5], 2'b0, w[2:0]};
    endfunction

    task automatic drive_random();
        word_t r, w;
        r = $random(seed);
        if_valid       = r[0];
        ex_allowin     = r[2:1] != 2'b00;
        ex_fwd.valid   = r[3];
        ex_fwd.is_load = r[5:4] == 2'b00;
        ex_fwd.dest    = {2'b0, r[8:6]};
        mem_fwd.valid  = r[9];
        mem_fwd.dest   = {2'b0, r[12:10]};
        wb_bus.we      = r[13];
        wb_bus.waddr   = {2'b0, r[16:14]};
        w = $random(seed);
        if_bus.inst    = make_inst(int'(r[31:17]) % 33, w);
        w = $random(seed);
        if_bus.pc      = {w[31:2], 2'b00};
        ex_fwd.wdata   = $random(seed);
        mem_fwd.wdata  = $random(seed);
        wb_bus.wdata   = $random(seed);
    endtask

    task automatic wait_allowin(input int limit, output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = id_allowin;
            n++;
        end
    endtask

    initial begin
        seed = SEED;
        resetn = 1'b0;
        if_valid = 1'b0;
        if_bus = '0;
        ex_allowin = 1'b1;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_bus = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        wait_allowin(10, ok);
        if (ok) begin
            for (int i = 1; i < 32; i++) begin
                @(negedge clk);
                wb_bus.we = 1'b1;
                wb_bus.waddr = i[4:0];
                wb_bus.wdata = $random(seed);
            end
            repeat (3000) begin
                @(negedge clk);
                drive_random();
            end
            @(negedge clk);
            if_valid = 1'b0;
            ex_allowin = 1'b1;
            ex_fwd.valid = 1'b0;
            wb_bus.we = 1'b0;
            wait_allowin(20, ok);
            repeat (2) @(negedge clk);
        end
        if (!ok)
            $display("timeout: id_allowin never went high");
        if (i_chk.leave_count == 0)
            $display("no record ever left the stage");
        $display("errors=%0d checks=%0d records=%0d taken=%0d", i_chk.err_count,
                 i_chk.check_count, i_chk.leave_count, i_chk.taken_count);
        if (ok && i_chk.err_count == 0 && i_chk.leave_count > 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* issue_stage.f */
+incdir+rtl
rtl/issue_pkg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_fwd.sv
rtl/branch_unit.sv
rtl/id_stage.sv
dv/tb_clkgen.sv
dv/id_checker.sv
dv/id_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= id_stage_tb
SEED      ?= 42578
LOG       ?= sim.log
FILELIST  ?= issue_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -GSEED=$(SEED) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation finished: PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
